/* project.f */
source/node_mem_pkg.sv
source/route_pkg.sv
source/node_memory.sv
source/rng_lfsr.sv
source/neighbor_index.sv
source/winner_policy.sv
source/route_select_top.sv
sim/tb_route_select.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_route_select -f project.f -o tb_route_select
./obj_dir/tb_route_select

/* sim/tb_route_select.sv */
`timescale 1ns/1ps

module tb_route_select;
	import node_mem_pkg::*;
	import route_pkg::*;

	localparam int n_fixed = 8;
	localparam int n_rows = 16; // fixed rows then random exploit rows
	localparam int watchdog_cycles = n_rows * 64;
	localparam word_t node_id = 16'h0042;

	typedef struct {
		word_t      eps;       // epsilon preload
		word_t      count;     // better list length
		int         hold;      // cycles res_ready stays low
		logic       explore;   // path the row must take
		route_req_t req;
		word_t      exp_hop;   // exploit rows only
		word_t      eps_after; // epsilon read back after the decision
	} row_t;

	logic clock, nrst;
	logic req_valid, req_ready, res_valid, res_ready;
	logic host_valid, host_ready, host_rvalid;
	route_req_t req;
	route_res_t res;
	host_req_t host;
	word_t host_rdata, my_node_id;
	row_t rows [n_rows];
	int n_built;
	integer seed;

	route_select_top i_route_select_top (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// whole run budget
	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired before all cases were done");
		stop_run();
	end

	task automatic stop_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_res(input route_res_t got, input route_res_t exp);
		if (got.nexthop !== exp.nexthop) begin
			$display("FAILED res.nexthop got 0x%h expected 0x%h", got.nexthop, exp.nexthop);
			stop_run();
		end
		if (got.explored !== exp.explored) begin
			$display("FAILED res.explored got 0x%h expected 0x%h", got.explored, exp.explored);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	// neighbor id kept in list slot k of a row
	function automatic word_t list_entry(int row, int k);
		return word_t'(32'h0A00 + row * 16 + k);
	endfunction

	function automatic word_t fill_word(addr_t a);
		return word_t'({a[4:0], a}) ^ 16'hC35A; // every address bit shows up
	endfunction

	// margin rules on 11.5 values with 0.16 and 1.15 margins
	function automatic word_t exploit_hop(word_t mybest, word_t bestvalue, word_t besthop,
			word_t nbr);
		logic [63:0] scaled, low_bound, high_bound;
		scaled     = 64'(bestvalue) << 16;
		low_bound  = 64'(mybest) * 64'(margin_low);
		high_bound = 64'(mybest) * (64'(margin_high) + 64'd32768); // 1.0 in 1.15 is 0x8000
		if (scaled < low_bound)
			return besthop;
		if (scaled < high_bound && nbr != node_id)
			return besthop;
		return no_hop;
	endfunction

	task automatic add_row(word_t eps, word_t count, int hold, logic explore, word_t mybest,
			word_t besthop, word_t bestvalue, word_t nbr, word_t step, word_t exp_hop,
			word_t eps_after);
		row_t r;
		r.eps       = eps;
		r.count     = count;
		r.hold      = hold;
		r.explore   = explore;
		r.req       = '{mybest: mybest, besthop: besthop, bestvalue: bestvalue,
			best_neighbor_id: nbr, epsilon_step: step};
		r.exp_hop   = exp_hop;
		r.eps_after = eps_after;
		rows[n_built] = r;
		n_built++;
	endtask

	task automatic host_write(input addr_t a, input word_t d);
		@(posedge clock);
		host_valid <= 1'b1;
		host       <= '{write: 1'b1, addr: a, wdata: d};
		do @(negedge clock); while (!host_ready);
		@(posedge clock); // transfer edge
		host_valid <= 1'b0;
	endtask

	task automatic host_read(input addr_t a, output word_t d);
		@(posedge clock);
		host_valid <= 1'b1;
		host       <= '{write: 1'b0, addr: a, wdata: 16'h0000};
		do @(negedge clock); while (!host_ready);
		@(posedge clock);
		host_valid <= 1'b0;
		do @(negedge clock); while (!host_rvalid);
		d = host_rdata;
	endtask

	task automatic send_req(input route_req_t r);
		@(posedge clock);
		req_valid <= 1'b1;
		req       <= r;
		do @(negedge clock); while (!req_ready);
		@(posedge clock);
		req_valid <= 1'b0;
	endtask

	task automatic run_case(input int row);
		row_t r;
		route_res_t got, exp;
		word_t eps_rd;
		int n_valid;
		r = rows[row];
		host_write(epsilon_addr, r.eps);
		host_write(better_count_addr, r.count);
		for (int k = 0; k < 4; k++) begin
			host_write(better_list_addr + addr_t'(2 * k), list_entry(row, k)); // slot 3 never valid
		end
		send_req(r.req);
		do @(negedge clock); while (!res_valid);
		got = res;
		repeat (r.hold) begin
			@(negedge clock);
			check_flag("res_valid", res_valid, 1'b1);
			check_flag("req_ready", req_ready, 1'b0);
			check_flag("host_ready", host_ready, 1'b0);
			check_res(res, got); // held result must not move
		end
		exp.explored = r.explore;
		exp.nexthop  = r.exp_hop;
		if (r.explore) begin
			n_valid = (r.count == 16'h0000) ? 1 : int'(r.count); // empty list falls back to slot 0
			exp.nexthop = no_hop;
			for (int k = 0; k < n_valid; k++) begin
				if (got.nexthop == list_entry(row, k))
					exp.nexthop = list_entry(row, k);
			end
			if (exp.nexthop == no_hop) begin
				$display("explore gave hop 0x%h which is not in the better list", got.nexthop);
				stop_run();
			end
		end
		check_res(got, exp);
		@(posedge clock);
		res_ready <= 1'b1;
		@(posedge clock);
		res_ready <= 1'b0;
		@(negedge clock);
		check_flag("res_valid", res_valid, 1'b0);
		host_read(epsilon_addr, eps_rd);
		check_word("epsilon", eps_rd, r.eps_after); // untouched on exploit
	endtask

	initial begin
		word_t mybest, besthop, bestvalue, nbr, rd;
		addr_t a;
		nrst       = 1'b0;
		req_valid  = 1'b0;
		req        = '0;
		res_ready  = 1'b0;
		host_valid = 1'b0;
		host       = '0;
		my_node_id = node_id;
		seed       = 32'ha7e6c8e7;
		n_built    = 0;

		add_row(16'h0000, 16'd3, 0, 1'b0, 16'h0400, 16'h0011, 16'h0200, 16'h0033, 16'h0001,
			16'h0011, 16'h0000); // far better
		add_row(16'h0000, 16'd3, 0, 1'b0, 16'h0400, 16'h0012, 16'h0400, 16'h0034, 16'h0001,
			16'h0012, 16'h0000); // in band with another node
		add_row(16'h0000, 16'd3, 0, 1'b0, 16'h0400, 16'h0013, 16'h0400, node_id, 16'h0001,
			no_hop, 16'h0000); // in band with own id
		add_row(16'h0000, 16'd3, 5, 1'b0, 16'h0400, 16'h0014, 16'h0800, 16'h0035, 16'h0001,
			no_hop, 16'h0000); // worse route and held
		add_row(16'hFFFF, 16'd3, 0, 1'b1, 16'h0400, 16'h0015, 16'h0200, 16'h0036, 16'h0100,
			no_hop, 16'hFEFF);
		add_row(16'h0010, 16'd1, 0, 1'b1, 16'h0400, 16'h0016, 16'h0200, 16'h0037, 16'h0020,
			no_hop, 16'h0000); // decay saturates
		add_row(16'h0010, 16'd0, 4, 1'b1, 16'h0400, 16'h0017, 16'h0200, 16'h0038, 16'h0005,
			no_hop, 16'h000B); // empty list and held
		add_row(16'hFFFF, 16'd2, 0, 1'b1, 16'h0400, 16'h0018, 16'h0200, 16'h0039, 16'hFFFF,
			no_hop, 16'h0000);
		for (int i = n_fixed; i < n_rows; i++) begin
			mybest    = word_t'(32'h0200 + ($random(seed) & 32'h1FFF));
			bestvalue = word_t'(int'(mybest) + ($random(seed) & 7) - 4); // near the band edges
			nbr       = (i % 2 == 1) ? node_id : word_t'(32'h0050 + i);
			besthop   = word_t'(32'h0020 + i);
			add_row(16'h0000, 16'd2, 0, 1'b0, mybest, besthop, bestvalue, nbr, 16'h0001,
				exploit_hop(mybest, bestvalue, besthop, nbr), 16'h0000);
		end

		repeat (4) @(posedge clock);
		nrst <= 1'b1;
		@(negedge clock);
		check_flag("req_ready", req_ready, 1'b1);
		check_flag("res_valid", res_valid, 1'b0);
		check_flag("host_rvalid", host_rvalid, 1'b0);

		// host port alone on scattered addresses
		for (int i = 0; i < 5; i++) begin
			a = addr_t'(i * 32'h16D + 32'h0B);
			host_write(a, fill_word(a));
		end
		for (int i = 0; i < 5; i++) begin
			a = addr_t'(i * 32'h16D + 32'h0B);
			host_read(a, rd);
			check_word("host_rdata", rd, fill_word(a));
		end

		for (int i = 0; i < n_rows; i++) begin
			run_case(i);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* source/neighbor_index.sv */
`timescale 1ns/1ps

module neighbor_index (
	input  logic                clock,
	input  logic                nrst,
	input  logic                start,
	input  route_pkg::rand_t    draw,
	input  node_mem_pkg::word_t count,
	output node_mem_pkg::word_t index,
	output logic                done
);
	import node_mem_pkg::*;

	word_t rem;       // remainder still being reduced
	word_t cnt;       // latched list length
	word_t value;     // operand of this cycle
	word_t count_sel;
	logic  running;

	// on start work straight off the inputs, saves a cycle
	assign value     = start ? {12'b0, draw} : rem;
	assign count_sel = start ? count : cnt;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			running <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0; // pulse
			if (start || running) begin
				if (count_sel == '0 || value < count_sel) begin
					running <= 1'b0;
					done    <= 1'b1;
				end else begin
					running <= 1'b1; // one subtraction per cycle
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			cnt <= count;
		end
		if (start || running) begin
			rem <= value - count_sel;
			// empty list falls back to entry 0
			index <= (count_sel == '0) ? '0 : value;
		end
	end

endmodule

/* source/node_mem_pkg.sv */
package node_mem_pkg;

	// node state memory geometry
	localparam int word_width = 16;
	localparam int addr_width = 11;
	localparam int mem_depth  = 2048;

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;

	// node state address map
	localparam addr_t epsilon_addr      = 11'h004; // exploration rate
	localparam addr_t better_list_addr  = 11'h668; // better neighbor ids, one every 2 words
	localparam addr_t better_count_addr = 11'h68C; // entries in the better list

	// host access to node memory
	typedef struct packed {
		logic  write; // 1 = write, 0 = read
		addr_t addr;
		word_t wdata;
	} host_req_t;

endpackage

/* source/node_memory.sv */
`timescale 1ns/1ps

module node_memory (
	input  logic                clock,
	input  logic                nrst,
	input  node_mem_pkg::addr_t addr,
	input  logic                wr,
	input  node_mem_pkg::word_t wdata,
	output node_mem_pkg::word_t rdata
);
	import node_mem_pkg::*;

	word_t mem [mem_depth]; // node state, contents survive reset

	// write port
	always_ff @(posedge clock) begin
		if (wr) begin
			mem[addr] <= wdata;
		end
	end

	// registered read, data one cycle after addr
	always_ff @(posedge clock) begin
		if (!nrst) begin
			rdata <= '0; // output register only
		end else begin
			rdata <= mem[addr]; // old data on a write to the same word
		end
	end

endmodule

/* source/rng_lfsr.sv */
`timescale 1ns/1ps

module rng_lfsr (
	input  logic             clock,
	input  logic             nrst,
	input  logic             req,
	output route_pkg::rand_t draw
);
	import route_pkg::*;

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;

	// right shifting galois form, taps folded in when bit 0 falls out
	assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			lfsr <= lfsr_seed;
		end else if (req) begin
			lfsr <= lfsr_next; // steps only on request
		end
	end

	// low nibble of the new state, valid the cycle after req
	always_ff @(posedge clock) begin
		if (req) begin
			draw <= lfsr_next[3:0];
		end
	end

endmodule

/* source/route_pkg.sv */
package route_pkg;

	// 0.999 as a pure 16 bit fraction (0.16)
	localparam logic [15:0] margin_low  = 16'b1111111110111110;
	// 1.001 with one integer bit (1.15)
	localparam logic [15:0] margin_high = 16'b1000000000100000;

	localparam node_mem_pkg::word_t no_hop = 16'hFFFF; // reserved, no route

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] lfsr_taps = 16'hB400;
	localparam logic [15:0] lfsr_seed = 16'hACE1; // must be nonzero

	typedef logic [3:0] rand_t;

	// one routing request, values in 11.5 fixed point
	typedef struct packed {
		node_mem_pkg::word_t mybest;
		node_mem_pkg::word_t besthop;
		node_mem_pkg::word_t bestvalue;
		node_mem_pkg::word_t best_neighbor_id;
		node_mem_pkg::word_t epsilon_step;
	} route_req_t;

	// decision result
	typedef struct packed {
		node_mem_pkg::word_t nexthop;
		logic                explored; // set when the hop came from the better list
	} route_res_t;

endpackage

/* source/route_select_top.sv */
`timescale 1ns/1ps

module route_select_top (
	input  logic                    clock,
	input  logic                    nrst,
	input  node_mem_pkg::word_t     my_node_id,
	input  logic                    req_valid,
	input  route_pkg::route_req_t   req,
	output logic                    req_ready,
	output logic                    res_valid,
	output route_pkg::route_res_t   res,
	input  logic                    res_ready,
	input  logic                    host_valid,
	input  node_mem_pkg::host_req_t host,
	output logic                    host_ready,
	output node_mem_pkg::word_t     host_rdata,
	output logic                    host_rvalid
);
	import node_mem_pkg::*;
	import route_pkg::*;

	addr_t mem_addr, pol_addr;
	word_t mem_wdata, pol_wdata, mem_rdata;
	logic  mem_wr, pol_wr;
	logic  busy, host_go;
	logic  rng_req, idx_start, idx_done;
	rand_t draw, idx_draw;
	word_t idx_count, idx_value;

	assign host_ready = !busy; // policy owns memory while busy
	assign host_go    = host_valid && host_ready;

	// memory mux
	assign mem_addr  = busy ? pol_addr : host.addr;
	assign mem_wr    = busy ? pol_wr : (host_go && host.write);
	assign mem_wdata = busy ? pol_wdata : host.wdata;

	assign host_rdata = mem_rdata; // registered read lines up with host_rvalid

	always_ff @(posedge clock) begin
		if (!nrst) begin
			host_rvalid <= 1'b0;
		end else begin
			host_rvalid <= host_go && !host.write;
		end
	end

	node_memory i_node_memory (
		.clock(clock), .nrst(nrst), .addr(mem_addr), .wr(mem_wr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

	rng_lfsr i_rng_lfsr (.clock(clock), .nrst(nrst), .req(rng_req), .draw(draw));

	neighbor_index i_neighbor_index (
		.clock(clock), .nrst(nrst), .start(idx_start), .draw(idx_draw),
		.count(idx_count), .index(idx_value), .done(idx_done)
	);

	winner_policy i_winner_policy (
		.clock(clock), .nrst(nrst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.res_valid(res_valid), .res(res), .res_ready(res_ready),
		.my_node_id(my_node_id),
		.mem_addr(pol_addr), .mem_wr(pol_wr), .mem_wdata(pol_wdata), .mem_rdata(mem_rdata),
		.busy(busy), .rng_req(rng_req), .draw(draw),
		.idx_start(idx_start), .idx_draw(idx_draw), .idx_count(idx_count),
		.idx_value(idx_value), .idx_done(idx_done)
	);

endmodule

/* source/winner_policy.sv */
`timescale 1ns/1ps

module winner_policy (
	input  logic                  clock,
	input  logic                  nrst,
	input  logic                  req_valid,
	input  route_pkg::route_req_t req,
	output logic                  req_ready,
	output logic                  res_valid,
	output route_pkg::route_res_t res,
	input  logic                  res_ready,
	input  node_mem_pkg::word_t   my_node_id,
	output node_mem_pkg::addr_t   mem_addr,
	output logic                  mem_wr,
	output node_mem_pkg::word_t   mem_wdata,
	input  node_mem_pkg::word_t   mem_rdata,
	output logic                  busy,
	output logic                  rng_req,
	input  route_pkg::rand_t      draw,
	output logic                  idx_start,
	output route_pkg::rand_t      idx_draw,
	output node_mem_pkg::word_t   idx_count,
	input  node_mem_pkg::word_t   idx_value,
	input  logic                  idx_done
);
	import node_mem_pkg::*;
	import route_pkg::*;

	typedef enum logic [4:0] {
		s_idle, s_draw, s_eps, s_choose,
		s_mul_low, s_cmp_low, s_mul_high, s_cmp_high, s_pick, // exploit
		s_cnt_rd, s_cnt, s_idx, s_hop_rd, s_hop, s_wb,         // explore
		s_finish, s_done
	} state_t;

	state_t     state;
	route_req_t req_q;      // request held for the whole decision
	rand_t      rand_q;
	word_t      eps_q;
	logic       explore;
	logic [31:0] left_q;    // bestvalue << 16
	logic [31:0] prod_low;  // mybest * 0.999
	logic [32:0] prod_high; // mybest * (1 + 1.001), one spare bit against overflow
	logic       below_low;
	logic       below_high;
	logic       id_diff;

	assign busy      = (state != s_idle);
	assign req_ready = (state == s_idle);
	assign explore   = ({12'b0, rand_q} < eps_q);

	// sequencing and strobes
	always_ff @(posedge clock) begin
		if (!nrst) begin
			state     <= s_idle;
			rng_req   <= 1'b0;
			idx_start <= 1'b0;
			mem_wr    <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			rng_req   <= 1'b0;
			idx_start <= 1'b0;
			mem_wr    <= 1'b0;
			case (state)
				s_idle: begin
					if (req_valid) begin
						rng_req <= 1'b1; // draw arrives with epsilon
						state   <= s_draw;
					end
				end
				s_draw:     state <= s_eps;
				s_eps:      state <= s_choose;
				s_choose:   state <= explore ? s_cnt_rd : s_mul_low;
				s_mul_low:  state <= s_cmp_low;
				s_cmp_low:  state <= s_mul_high;
				s_mul_high: state <= s_cmp_high;
				s_cmp_high: state <= s_pick;
				s_pick:     state <= s_finish;
				s_cnt_rd:   state <= s_cnt; // count read in flight
				s_cnt: begin
					idx_start <= 1'b1;
					state     <= s_idx;
				end
				s_idx: begin
					if (idx_done) state <= s_hop_rd;
				end
				s_hop_rd:   state <= s_hop; // neighbor id read in flight
				s_hop: begin
					mem_wr <= 1'b1; // epsilon write back
					state  <= s_wb;
				end
				s_wb:       state <= s_finish;
				s_finish: begin
					res_valid <= 1'b1;
					state     <= s_done;
				end
				s_done: begin
					// hold result until taken
					if (res_ready) begin
						res_valid <= 1'b0;
						state     <= s_idle;
					end
				end
				default:    state <= s_idle;
			endcase
		end
	end

	// datapath, follows the state
	always_ff @(posedge clock) begin
		case (state)
			s_idle: begin
				if (req_valid) begin
					req_q    <= req;
					mem_addr <= epsilon_addr;
				end
			end
			s_eps: begin
				rand_q <= draw;
				eps_q  <= mem_rdata;
			end
			s_choose: mem_addr <= better_count_addr; // unused on exploit
			s_mul_low: begin
				left_q   <= {req_q.bestvalue, 16'b0};
				prod_low <= {16'b0, req_q.mybest} * {16'b0, margin_low};
			end
			s_cmp_low: below_low <= (left_q < prod_low); // far better than own route
			s_mul_high: begin
				prod_high <= {17'b0, req_q.mybest} * {17'b0, margin_high}
					+ {2'b0, req_q.mybest, 15'b0};
			end
			s_cmp_high: begin
				below_high <= ({1'b0, left_q} < prod_high);
				id_diff    <= (req_q.best_neighbor_id != my_node_id); // never route to self
			end
			s_pick: begin
				res.nexthop  <= (below_low || (below_high && id_diff)) ? req_q.besthop : no_hop;
				res.explored <= 1'b0;
			end
			s_cnt: begin
				idx_draw  <= rand_q;
				idx_count <= mem_rdata;
			end
			s_idx: begin
				if (idx_done) begin
					mem_addr <= better_list_addr + addr_t'({idx_value, 1'b0}); // 2 words per entry
				end
			end
			s_hop: begin
				res.nexthop  <= mem_rdata;
				res.explored <= 1'b1;
				mem_addr     <= epsilon_addr;
				// decay, saturating at zero
				mem_wdata <= (eps_q < req_q.epsilon_step) ? '0 : eps_q - req_q.epsilon_step;
			end
			default: ;
		endcase
	end

endmodule
